// File: dcache.f
+incdir+source
source/dcache_line_pkg.sv
source/dcache_req_pkg.sv
source/dcache_way.sv
source/dcache_ctrl.sv
source/dcache_top.sv
sim/dcache_props.sv
sim/dcache_tb.sv

// File: sim/dcache_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb
	import dcache_line_pkg::*;
();

	localparam int WAIT_LIMIT = 200;

	logic CLK;
	logic RESET;
	logic cache_read;
	logic cache_write;
	logic [`DC_ADDR_W-1:0] data_address;
	logic [`DC_WORD_W-1:0] data_write;
	logic [1:0] data_write_size;
	logic [`DC_WORD_W-1:0] data_read;
	logic miss;
	logic mem_read_req;
	logic [`DC_ADDR_W-1:0] mem_read_addr;
	line_data_t mem_read_data;
	logic mem_read_valid;
	logic mem_write_req;
	logic [`DC_ADDR_W-1:0] mem_write_addr;
	line_data_t mem_write_data;
	logic mem_write_valid;

	logic [15:0] lfsr_state = 16'd41;
	line_data_t mem_lines [logic [31:0]];
	logic [31:0] exp_words [logic [31:0]];
	bit ref_valid [2][`DC_SETS];
	bit ref_dirty [2][`DC_SETS];
	tag_t ref_tag [2][`DC_SETS];
	bit ref_lru [`DC_SETS];
	int errors = 0;
	int checks = 0;
	int tests = 0;
	bit timed_out = 0;

	dcache_top uut (
		.CLK(CLK),
		.RESET(RESET),
		.cache_read(cache_read),
		.cache_write(cache_write),
		.data_address(data_address),
		.data_write(data_write),
		.data_write_size(data_write_size),
		.data_read(data_read),
		.miss(miss),
		.mem_read_req(mem_read_req),
		.mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data),
		.mem_read_valid(mem_read_valid),
		.mem_write_req(mem_write_req),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data),
		.mem_write_valid(mem_write_valid)
	);

	initial
		CLK = 1'b0;
	always #10 CLK = ~CLK;

	// ########################################
	// helpers

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] make_addr(input tag_t t, input index_t ix, input logic [4:0] o);
		return {t, ix, o};
	endfunction

	function automatic logic [31:0] word_value(input logic [31:0] waddr);
		return exp_words.exists(waddr) ? exp_words[waddr] : waddr;
	endfunction

	function automatic line_data_t expected_line(input logic [31:0] line_addr);
		line_data_t l;
		for (int i = 0; i < `DC_WORDS; i++)
			l[`DC_LINE_W-1 - 32*i -: 32] = word_value(line_addr + 4*i);
		return l;
	endfunction

	// untouched memory holds each word's own address
	function automatic line_data_t line_value(input logic [31:0] line_addr);
		line_data_t l;
		for (int i = 0; i < `DC_WORDS; i++)
			l[`DC_LINE_W-1 - 32*i -: 32] = line_addr + 4*i;
		return mem_lines.exists(line_addr) ? mem_lines[line_addr] : l;
	endfunction

	function automatic int store_bytes(input logic [1:0] size);
		return (size == 2'd0) ? 4 : int'(size);
	endfunction

	// big-endian: lowest wdata byte lands on the highest offset
	function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [1:0] offs,
		input logic [1:0] size, input logic [31:0] wdata);
		int n;
		logic [31:0] w;
		n = store_bytes(size);
		w = old;
		for (int j = 0; j < n; j++)
			w[8*(3 - int'(offs) - j) +: 8] = wdata[8*(n - 1 - j) +: 8];
		return w;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Mismatch at time %0d: %s", $time, msg);
		errors++;
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic print_test_result(input string name, input int errors_before);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
	endtask

	task automatic go_idle();
		@(posedge CLK);
		cache_read <= 1'b0;
		cache_write <= 1'b0;
	endtask

	// ########################################
	// one processor access with reference model update

	task automatic access(input bit is_write, input logic [31:0] addr,
		input logic [1:0] size, input logic [31:0] wdata);
		index_t set;
		tag_t tag;
		logic [31:0] waddr;
		int way;
		int victim;
		bit exp_wb;
		bit saw_wb;
		bit saw_rd;
		int cycles;
		set = addr[`DC_OFFS_W +: `DC_INDEX_W];
		tag = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
		waddr = {addr[31:2], 2'b00};
		way = -1;
		for (int w = 0; w < 2; w++)
			if (ref_valid[w][set] && ref_tag[w][set] == tag)
				way = w;
		victim = ref_lru[set];
		exp_wb = (way < 0) && ref_valid[victim][set] && ref_dirty[victim][set];
		saw_wb = 0;
		saw_rd = 0;
		cycles = 0;
		if (timed_out)
			return;
		@(posedge CLK);
		cache_read <= !is_write;
		cache_write <= is_write;
		data_address <= addr;
		data_write_size <= size;
		data_write <= wdata;
		@(negedge CLK);
		checks++;
		assert (miss == (way < 0))
			else report_mismatch($sformatf("miss %b for %h, expected %b", miss, addr, way < 0));
		while (miss && cycles < WAIT_LIMIT)
		begin
			if (mem_write_req && !saw_wb)
			begin
				saw_wb = 1;
				checks++;
				assert (mem_write_addr == {ref_tag[victim][set], set, 5'b0}
					&& mem_write_data == expected_line({ref_tag[victim][set], set, 5'b0}))
					else report_mismatch($sformatf("writeback of %h wrong", mem_write_addr));
			end
			if (mem_read_req && !saw_rd)
			begin
				saw_rd = 1;
				checks++;
				assert (mem_read_addr == {tag, set, 5'b0})
					else report_mismatch($sformatf("refill address %h for %h", mem_read_addr, addr));
				checks++;
				assert (saw_wb == exp_wb)
					else report_failure($sformatf("writeback %s before refill of %h",
						exp_wb ? "missing" : "not expected", addr));
			end
			@(negedge CLK);
			cycles++;
		end
		if (miss)
		begin
			timed_out = 1;
			report_failure($sformatf("Timeout: miss still high after %0d cycles for %h",
				WAIT_LIMIT, addr));
			return;
		end
		if (way < 0)
		begin
			checks++;
			assert (saw_rd)
				else report_failure($sformatf("no refill request seen for %h", addr));
			way = victim;
			ref_valid[way][set] = 1;
			ref_tag[way][set] = tag;
			ref_dirty[way][set] = 0;
		end
		ref_lru[set] = (way == 0);
		if (!is_write)
		begin
			checks++;
			assert (data_read === word_value(waddr))
				else report_mismatch($sformatf("read %h gave %h, expected %h",
					addr, data_read, word_value(waddr)));
		end
		else if (int'(addr[1:0]) + store_bytes(size) <= 4)
		begin
			exp_words[waddr] = merge_store(word_value(waddr), addr[1:0], size, wdata);
			ref_dirty[way][set] = 1;
		end
	endtask

	// ########################################
	// memory model

	initial
	begin : memory_model
		int delay;
		bit is_wr;
		logic [31:0] a;
		line_data_t d;
		mem_read_valid = 1'b0;
		mem_write_valid = 1'b0;
		mem_read_data = '0;
		forever
		begin
			@(negedge CLK);
			if (RESET && (mem_write_req || mem_read_req))
			begin
				is_wr = mem_write_req;
				a = is_wr ? mem_write_addr : mem_read_addr;
				d = mem_write_data;
				delay = lfsr_take(3);
				repeat (delay) @(posedge CLK);
				@(posedge CLK);
				if (is_wr)
				begin
					mem_lines[a] = d;
					mem_write_valid <= 1'b1;
				end
				else
				begin
					mem_read_data <= line_value(a);
					mem_read_valid <= 1'b1;
				end
				@(posedge CLK);
				mem_write_valid <= 1'b0;
				mem_read_valid <= 1'b0;
			end
		end
	end

	// ########################################
	// stimulus

	initial
	begin : stimulus
		int mark;
		logic [31:0] base;
		tag_t t;
		index_t ix;
		bit is_wr;
		logic [4:0] o;
		logic [1:0] sz;
		logic [31:0] wd;
		RESET = 1'b0;
		cache_read = 1'b0;
		cache_write = 1'b0;
		data_address = '0;
		data_write = '0;
		data_write_size = '0;
		repeat (8) @(posedge CLK);
		RESET <= 1'b1;

		mark = errors;
		@(negedge CLK);
		checks++;
		assert (!mem_read_req && !mem_write_req)
			else report_mismatch("memory request high after reset");
		access(0, make_addr(18'h3, 9'h010, 5'h08), 2'd0, 32'h0);
		go_idle();
		print_test_result("reset and cold miss", mark);

		mark = errors;
		base = make_addr(18'h5, 9'h020, 5'h04);
		for (int s = 0; s < 4; s++)
			for (int off = 0; off < 4; off++)
			begin
				wd = lfsr_take(32);
				access(1, base + off, 2'(s), wd);
				access(0, base, 2'd0, 32'h0);
			end
		go_idle();
		print_test_result("partial stores", mark);

		mark = errors;
		access(0, make_addr(18'h1, 9'h030, 5'h00), 2'd0, 32'h0);
		access(0, make_addr(18'h2, 9'h030, 5'h04), 2'd0, 32'h0);
		access(0, make_addr(18'h1, 9'h030, 5'h08), 2'd0, 32'h0);
		access(0, make_addr(18'h3, 9'h030, 5'h0c), 2'd0, 32'h0);
		access(0, make_addr(18'h1, 9'h030, 5'h10), 2'd0, 32'h0);
		access(0, make_addr(18'h2, 9'h030, 5'h14), 2'd0, 32'h0);
		go_idle();
		print_test_result("two ways and lru", mark);

		mark = errors;
		access(1, make_addr(18'h7, 9'h040, 5'h0c), 2'd0, lfsr_take(32));
		access(1, make_addr(18'h7, 9'h040, 5'h19), 2'd1, lfsr_take(32));
		access(0, make_addr(18'h8, 9'h040, 5'h00), 2'd0, 32'h0);
		access(0, make_addr(18'h9, 9'h040, 5'h00), 2'd0, 32'h0);
		access(0, make_addr(18'h7, 9'h040, 5'h0c), 2'd0, 32'h0);
		access(0, make_addr(18'h7, 9'h040, 5'h18), 2'd0, 32'h0);
		go_idle();
		print_test_result("dirty writeback", mark);

		mark = errors;
		access(0, make_addr(18'ha, 9'h050, 5'h00), 2'd0, 32'h0);
		access(0, make_addr(18'hb, 9'h050, 5'h00), 2'd0, 32'h0);
		access(0, make_addr(18'hc, 9'h050, 5'h00), 2'd0, 32'h0);
		for (int i = 0; i < 24; i++)
		begin
			t = 18'h10 + lfsr_take(2);
			ix = lfsr_take(1) ? 9'h060 : 9'h061;
			is_wr = lfsr_take(1);
			o = lfsr_take(5);
			sz = lfsr_take(2);
			wd = lfsr_take(32);
			access(is_wr, make_addr(t, ix, o), sz, wd);
		end
		go_idle();
		print_test_result("clean eviction and back-pressure", mark);

		if (uut.props_inst.fail_count != 0)
			report_failure($sformatf("%0d memory protocol assertions failed",
				uut.props_inst.fail_count));
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0 && !timed_out)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/dcache_props.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_props
(
	input logic CLK,
	input logic RESET,
	input logic mem_read_req,
	input logic mem_write_req,
	input logic mem_read_valid,
	input logic mem_write_valid
);

	int fail_count = 0;

	// one memory transaction at a time
	assert property (@(posedge CLK) disable iff (!RESET) !(mem_read_req && mem_write_req))
		else
		begin
			fail_count++;
			$error("read and write requests high together");
		end

	assert property (@(posedge CLK) $rose(RESET) |-> !mem_read_req && !mem_write_req)
		else
		begin
			fail_count++;
			$error("memory request high right after reset");
		end

	// ########################################
	// requests are held until memory answers

	assert property (@(posedge CLK) disable iff (!RESET)
		mem_read_req && !mem_read_valid |=> mem_read_req)
		else
		begin
			fail_count++;
			$error("read request dropped before read valid");
		end

	assert property (@(posedge CLK) disable iff (!RESET)
		mem_write_req && !mem_write_valid |=> mem_write_req)
		else
		begin
			fail_count++;
			$error("write request dropped before write valid");
		end

	// writeback always leads into a refill
	assert property (@(posedge CLK) disable iff (!RESET)
		mem_write_req && mem_write_valid |=> mem_read_req)
		else
		begin
			fail_count++;
			$error("no read request after writeback");
		end

endmodule

bind dcache_top dcache_props props_inst (
	.CLK(CLK),
	.RESET(RESET),
	.mem_read_req(mem_read_req),
	.mem_write_req(mem_write_req),
	.mem_read_valid(mem_read_valid),
	.mem_write_valid(mem_write_valid)
);

`default_nettype wire

// File: source/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_top
	import dcache_line_pkg::*, dcache_req_pkg::*;
(
	input logic CLK,
	input logic RESET,

	// processor side
	input logic cache_read,
	input logic cache_write,
	input logic [`DC_ADDR_W-1:0] data_address,
	input logic [`DC_WORD_W-1:0] data_write,
	input logic [1:0] data_write_size,
	output logic [`DC_WORD_W-1:0] data_read,
	output logic miss,

	// memory side
	output logic mem_read_req,
	output logic [`DC_ADDR_W-1:0] mem_read_addr,
	input line_data_t mem_read_data,
	input logic mem_read_valid,
	output logic mem_write_req,
	output logic [`DC_ADDR_W-1:0] mem_write_addr,
	output line_data_t mem_write_data,
	input logic mem_write_valid
);

	cpu_req_t req;
	index_t lookup_index;
	way_lookup_t lookup0;
	way_lookup_t lookup1;
	store_cmd_t store0;
	store_cmd_t store1;
	way_fill_t fill0;
	way_fill_t fill1;

	assign req.read = cache_read;
	assign req.write = cache_write;
	assign req.addr = data_address;
	assign req.size = store_size_e'(data_write_size);
	assign req.wdata = data_write;

	assign lookup_index = data_address[`DC_OFFS_W +: `DC_INDEX_W];

	dcache_way way0_inst (
		.CLK(CLK),
		.RESET(RESET),
		.lookup_index(lookup_index),
		.store(store0),
		.fill(fill0),
		.lookup(lookup0)
	);

	dcache_way way1_inst (
		.CLK(CLK),
		.RESET(RESET),
		.lookup_index(lookup_index),
		.store(store1),
		.fill(fill1),
		.lookup(lookup1)
	);

	dcache_ctrl ctrl_inst (
		.CLK(CLK),
		.RESET(RESET),
		.req(req),
		.lookup0(lookup0),
		.lookup1(lookup1),
		.mem_read_data(mem_read_data),
		.mem_read_valid(mem_read_valid),
		.mem_write_valid(mem_write_valid),
		.store0(store0),
		.store1(store1),
		.fill0(fill0),
		.fill1(fill1),
		.data_read(data_read),
		.miss(miss),
		.mem_read_req(mem_read_req),
		.mem_write_req(mem_write_req),
		.mem_read_addr(mem_read_addr),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data)
	);

endmodule

`default_nettype wire

// File: source/dcache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_ctrl
	import dcache_line_pkg::*, dcache_req_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input cpu_req_t req,
	input way_lookup_t lookup0,
	input way_lookup_t lookup1,
	input line_data_t mem_read_data,
	input logic mem_read_valid,
	input logic mem_write_valid,
	output store_cmd_t store0,
	output store_cmd_t store1,
	output way_fill_t fill0,
	output way_fill_t fill1,
	output logic [`DC_WORD_W-1:0] data_read,
	output logic miss,
	output logic mem_read_req,
	output logic mem_write_req,
	output logic [`DC_ADDR_W-1:0] mem_read_addr,
	output logic [`DC_ADDR_W-1:0] mem_write_addr,
	output line_data_t mem_write_data
);

	tag_t req_tag;
	index_t req_index;
	word_sel_t req_word;
	logic [1:0] req_byte;
	logic access;
	logic hit0;
	logic hit1;
	logic hit;
	line_data_t hit_line;

	logic [3:0] size_mask;
	logic [2:0] size_bytes;
	logic [2:0] lane_end;
	logic lane_ok;
	logic [1:0] lane_shift;
	store_cmd_t store_cmd;

	logic [`DC_SETS-1:0] lru;
	logic victim_way;
	way_lookup_t victim;

	ctrl_state_e state;
	ctrl_state_e state_next;
	logic fill_now;
	logic saved_way;
	tag_t saved_req_tag;
	index_t saved_index;
	tag_t saved_tag;
	line_data_t saved_line;

	// ######################################
	// lookup

	assign req_tag = req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
	assign req_index = req.addr[`DC_OFFS_W +: `DC_INDEX_W];
	assign req_word = req.addr[`DC_OFFS_W-1:2];
	assign req_byte = req.addr[1:0];

	assign access = req.read | req.write;
	assign hit0 = lookup0.valid && (lookup0.tag == req_tag);
	assign hit1 = lookup1.valid && (lookup1.tag == req_tag);
	assign hit = hit0 | hit1;
	assign miss = access & ~hit;

	assign hit_line = hit1 ? lookup1.data : lookup0.data;
	assign data_read = hit_line[`DC_LINE_W-1 - `DC_WORD_W*req_word -: `DC_WORD_W];

	// ######################################
	// store alignment

	always_comb
	begin
		case (req.size)
			SZ_BYTE:
				size_mask = 4'b0001;
			SZ_HALF:
				size_mask = 4'b0011;
			SZ_TRIPLE:
				size_mask = 4'b0111;
			default:
				size_mask = 4'b1111;
		endcase
	end

	assign size_bytes = (req.size == SZ_WORD) ? 3'd4 : {1'b0, req.size};
	// one past the last byte touched
	assign lane_end = {1'b0, req_byte} + size_bytes;
	assign lane_ok = (lane_end <= 3'd4);
	assign lane_shift = 2'(3'd4 - lane_end);

	always_comb
	begin
		store_cmd.en = (state == IDLE) && req.write && lane_ok;
		store_cmd.index = req_index;
		store_cmd.word = req_word;
		store_cmd.mask = size_mask << lane_shift;
		store_cmd.wdata = req.wdata << {lane_shift, 3'b000};

		store0 = store_cmd;
		store0.en = store_cmd.en & hit0;
		store1 = store_cmd;
		store1.en = store_cmd.en & hit1;
	end

	// ######################################
	// replacement

	// bit set means way 1 is the next victim
	assign victim_way = lru[req_index];
	assign victim = victim_way ? lookup1 : lookup0;

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			lru <= '0;
		else if (fill_now)
			lru[saved_index] <= ~saved_way;
		else if (access && hit)
			lru[req_index] <= hit0;
	end

	// ######################################
	// miss handling

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
				if (miss)
					state_next = (victim.valid && victim.dirty) ? WRITEBACK : REFILL;
			WRITEBACK:
				if (mem_write_valid)
					state_next = REFILL;
			REFILL:
				if (mem_read_valid)
					state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			state <= IDLE;
		else
			state <= state_next;
	end

	// victim snapshot taken when the miss is first seen
	always_ff @(posedge CLK)
	begin
		if (state == IDLE && miss)
		begin
			saved_way <= victim_way;
			saved_req_tag <= req_tag;
			saved_index <= req_index;
			saved_tag <= victim.tag;
			saved_line <= victim.data;
		end
	end

	assign mem_write_req = (state == WRITEBACK);
	assign mem_read_req = (state == REFILL);
	assign mem_write_addr = {saved_tag, saved_index, {`DC_OFFS_W{1'b0}}};
	assign mem_read_addr = {saved_req_tag, saved_index, {`DC_OFFS_W{1'b0}}};
	assign mem_write_data = saved_line;

	assign fill_now = (state == REFILL) && mem_read_valid;

	always_comb
	begin
		fill0.en = fill_now & ~saved_way;
		fill0.index = saved_index;
		fill0.tag = saved_req_tag;
		fill0.data = mem_read_data;

		fill1 = fill0;
		fill1.en = fill_now & saved_way;
	end

endmodule

`default_nettype wire

// File: source/dcache_way.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_way
	import dcache_line_pkg::*, dcache_req_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input index_t lookup_index,
	input store_cmd_t store,
	input way_fill_t fill,
	output way_lookup_t lookup
);

	line_data_t data_mem [`DC_SETS];
	tag_t tag_mem [`DC_SETS];
	logic [`DC_SETS-1:0] valid;
	logic [`DC_SETS-1:0] dirty;

	always_comb
	begin
		lookup.valid = valid[lookup_index];
		lookup.dirty = dirty[lookup_index];
		lookup.tag = tag_mem[lookup_index];
		lookup.data = data_mem[lookup_index];
	end

	// line and tag storage
	always_ff @(posedge CLK)
	begin
		if (fill.en)
		begin
			data_mem[fill.index] <= fill.data;
			tag_mem[fill.index] <= fill.tag;
		end
		else if (store.en)
		begin
			// merge only the enabled byte lanes of the addressed word
			for (int b = 0; b < 4; b++)
			begin
				if (store.mask[b])
					data_mem[store.index][`DC_LINE_W - `DC_WORD_W*(store.word + 1) + 8*b +: 8]
						<= store.wdata[8*b +: 8];
			end
		end
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			valid <= '0;
			dirty <= '0;
		end
		else if (fill.en)
		begin
			valid[fill.index] <= 1'b1;
			dirty[fill.index] <= 1'b0;
		end
		else if (store.en)
			dirty[store.index] <= 1'b1;
	end

endmodule

`default_nettype wire

// File: source/dcache_req_pkg.sv
`default_nettype none

`include "dcache_consts.svh"

package dcache_req_pkg;

	typedef enum logic [1:0] {
		SZ_WORD = 2'd0,
		SZ_BYTE = 2'd1,
		SZ_HALF = 2'd2,
		SZ_TRIPLE = 2'd3
	} store_size_e;

	typedef logic [$clog2(`DC_WORDS)-1:0] word_sel_t;

	typedef struct packed {
		logic read;
		logic write;
		logic [`DC_ADDR_W-1:0] addr;
		store_size_e size;
		logic [`DC_WORD_W-1:0] wdata;
	} cpu_req_t;

	// mask bit 3 is the byte at offset 0 (big-endian)
	typedef struct packed {
		logic en;
		dcache_line_pkg::index_t index;
		word_sel_t word;
		logic [3:0] mask;
		logic [`DC_WORD_W-1:0] wdata;
	} store_cmd_t;

	typedef enum logic [1:0] {
		IDLE,
		WRITEBACK,
		REFILL
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: source/dcache_line_pkg.sv
`default_nettype none

`include "dcache_consts.svh"

package dcache_line_pkg;

	// word 0 sits in the top 32 bits
	typedef logic [`DC_LINE_W-1:0] line_data_t;
	typedef logic [`DC_TAG_W-1:0] tag_t;
	typedef logic [`DC_INDEX_W-1:0] index_t;

	// one way's entry at the current index
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
		line_data_t data;
	} way_lookup_t;

	// whole-line write from memory
	typedef struct packed {
		logic en;
		index_t index;
		tag_t tag;
		line_data_t data;
	} way_fill_t;

endpackage

`default_nettype wire

// File: source/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address split is tag | index | byte offset
`define DC_ADDR_W 32
`define DC_TAG_W 18
`define DC_INDEX_W 9
`define DC_OFFS_W 5

// data widths
`define DC_WORD_W 32
`define DC_LINE_W 256

// geometry
`define DC_SETS 512
`define DC_WORDS 8

`endif
